//--- src.f
+incdir+hdl
hdl/apb_bridge_pkg.sv
hdl/axi_lite_req.sv
hdl/apb_addr_decode.sv
hdl/apb_master_seq.sv
hdl/apb_resp_mux.sv
hdl/apb_bridge_top.sv
bench/apb_periph_model.sv
bench/tb_apb_bridge.sv

//--- Bender.yml
package:
  name: apb_bridge

export_include_dirs:
  - hdl

sources:
  - hdl/apb_bridge_pkg.sv
  - hdl/axi_lite_req.sv
  - hdl/apb_addr_decode.sv
  - hdl/apb_master_seq.sv
  - hdl/apb_resp_mux.sv
  - hdl/apb_bridge_top.sv
  - target: test
    files:
      - bench/apb_periph_model.sv
      - bench/tb_apb_bridge.sv

//--- bench/tb_apb_bridge.sv
`timescale 1ns/10ps
`default_nettype none
`include "apb_bridge_settings.svh"

module tb_apb_bridge;

    import apb_bridge_pkg::*;

    localparam int TMO = 200;

    logic                      S_AXI_ACLK;
    logic                      S_AXI_ARESETN;
    logic [`BRIDGE_ADDR_W-1:0] s_axi_awaddr;
    logic [2:0]                s_axi_awprot;
    logic                      s_axi_awvalid;
    logic                      s_axi_awready;
    logic [`BRIDGE_DATA_W-1:0] s_axi_wdata;
    logic [3:0]                s_axi_wstrb;
    logic                      s_axi_wvalid;
    logic                      s_axi_wready;
    axi_resp_t                 s_axi_bresp;
    logic                      s_axi_bvalid;
    logic                      s_axi_bready;
    logic [`BRIDGE_ADDR_W-1:0] s_axi_araddr;
    logic [2:0]                s_axi_arprot;
    logic                      s_axi_arvalid;
    logic                      s_axi_arready;
    logic [`BRIDGE_DATA_W-1:0] s_axi_rdata;
    axi_resp_t                 s_axi_rresp;
    logic                      s_axi_rvalid;
    logic                      s_axi_rready;
    logic [`APB_DEV_COUNT-1:0] psel;
    logic                      penable;
    logic [`BRIDGE_ADDR_W-1:0] paddr;
    logic                      pwrite;
    logic [`BRIDGE_DATA_W-1:0] pwdata;
    logic [`BRIDGE_DATA_W-1:0] prdata [`APB_DEV_COUNT];
    logic [`APB_DEV_COUNT-1:0] pready;
    logic [`APB_DEV_COUNT-1:0] pslverr;
    logic [1:0]                wait_cfg;

    logic [`BRIDGE_DATA_W-1:0] shadow [`APB_DEV_COUNT][16];  // last OKAY write per word
    logic [15:0]               lfsr;
    logic [`BRIDGE_ADDR_W-1:0] exp_waddr;
    logic [`BRIDGE_ADDR_W-1:0] exp_raddr;
    logic [`BRIDGE_DATA_W-1:0] exp_wdata;
    logic [`BRIDGE_DATA_W-1:0] exp_rdata;
    axi_resp_t                 exp_bresp;
    axi_resp_t                 exp_rresp;
    logic                      quiet_bus;
    logic                      order_check;
    logic                      wr_setup_seen;
    int                        data_errs;
    int                        proto_errs;
    int                        tmo_errs;

    apb_bridge_top dut (.*);
    apb_periph_model u_periph (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic axi_resp_t expected_resp(input logic [`BRIDGE_ADDR_W-1:0] a);
        if (|a[`BRIDGE_ADDR_W-1:15])
            return RESP_DECERR;
        if (a[11:0] == 12'h0FC)
            return RESP_SLVERR;
        return RESP_OKAY;
    endfunction

    function automatic logic signal_level(input string what);
        case (what)
            "awready": return s_axi_awready;
            "wready":  return s_axi_wready;
            "arready": return s_axi_arready;
            "bvalid":  return s_axi_bvalid;
            default:   return s_axi_rvalid;
        endcase
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        data_errs++;
        $display("Mismatch %s got %h expected %h", name, got, exp);
    endtask

    task automatic protocol_error(input string what);
        proto_errs++;
        $display("protocol error: %s", what);
    endtask

    // checked and changed on falling edges only
    task automatic wait_until_high(input string what);
        int n;
        n = 0;
        while (!signal_level(what) && n < TMO) begin
            @(negedge S_AXI_ACLK);
            n++;
        end
        if (!signal_level(what)) begin
            tmo_errs++;
            $display("timeout waiting for %s", what);
        end
    endtask

    task automatic axi_write(input logic [`BRIDGE_ADDR_W-1:0] a, input logic [31:0] d,
                             input int aw_lag, input int w_lag, input int b_hold);
        exp_waddr = a;
        exp_wdata = d;
        exp_bresp = expected_resp(a);
        quiet_bus = (exp_bresp == RESP_DECERR);
        wait_cfg  = 2'(rand_bits(2));
        fork
            begin
                repeat (aw_lag) @(negedge S_AXI_ACLK);
                s_axi_awaddr  = a;
                s_axi_awvalid = 1'b1;
                wait_until_high("awready");
                @(negedge S_AXI_ACLK);
                s_axi_awvalid = 1'b0;
            end
            begin
                repeat (w_lag) @(negedge S_AXI_ACLK);
                s_axi_wdata  = d;
                s_axi_wvalid = 1'b1;
                wait_until_high("wready");
                @(negedge S_AXI_ACLK);
                s_axi_wvalid = 1'b0;
            end
        join
        wait_until_high("bvalid");
        repeat (b_hold) @(negedge S_AXI_ACLK);  // back-pressure stretch
        s_axi_bready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_bready = 1'b0;
        if (exp_bresp == RESP_OKAY)
            shadow[a[14:12]][a[5:2]] = d;
        quiet_bus = 1'b0;
    endtask

    task automatic axi_read(input logic [`BRIDGE_ADDR_W-1:0] a, input int r_hold);
        exp_raddr = a;
        exp_rresp = expected_resp(a);
        exp_rdata = shadow[a[14:12]][a[5:2]];
        quiet_bus = (exp_rresp == RESP_DECERR);
        wait_cfg  = 2'(rand_bits(2));
        s_axi_araddr  = a;
        s_axi_arvalid = 1'b1;
        wait_until_high("arready");
        @(negedge S_AXI_ACLK);
        s_axi_arvalid = 1'b0;
        wait_until_high("rvalid");
        repeat (r_hold) @(negedge S_AXI_ACLK);
        s_axi_rready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_rready = 1'b0;
        quiet_bus = 1'b0;
    endtask

    // write setup seen before the read one
    always @(posedge S_AXI_ACLK) begin
        if (!order_check)
            wr_setup_seen <= 1'b0;
        else if (|psel && pwrite)
            wr_setup_seen <= 1'b1;
    end

    a_bresp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid |-> s_axi_bresp == exp_bresp)
        else mismatch("s_axi_bresp", s_axi_bresp, exp_bresp);
    a_rresp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid |-> s_axi_rresp == exp_rresp)
        else mismatch("s_axi_rresp", s_axi_rresp, exp_rresp);
    a_rdata: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && exp_rresp == RESP_OKAY |-> s_axi_rdata == exp_rdata)
        else mismatch("s_axi_rdata", s_axi_rdata, exp_rdata);
    a_psel: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        |psel |-> psel == (8'd1 << paddr[14:12]))
        else mismatch("psel", psel, 8'd1 << paddr[14:12]);
    a_waddr: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        |psel && pwrite |-> paddr == exp_waddr)
        else mismatch("paddr", paddr, exp_waddr);
    a_wdata: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        |psel && pwrite |-> pwdata == exp_wdata)
        else mismatch("pwdata", pwdata, exp_wdata);
    a_raddr: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        |psel && !pwrite |-> paddr == exp_raddr)
        else mismatch("paddr", paddr, exp_raddr);
    a_setup: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        |psel && !penable |=> penable)
        else protocol_error("SETUP not followed by ACCESS");
    a_access: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(penable) |-> $past(|psel && !penable))
        else protocol_error("PENABLE rose without a SETUP cycle");
    a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
        else protocol_error("write response dropped or changed before BREADY");
    a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
        && $stable(s_axi_rresp))
        else protocol_error("read response dropped or changed before RREADY");
    a_w_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid |-> !s_axi_awready && !s_axi_wready)
        else protocol_error("AWREADY or WREADY high while BVALID pending");
    a_r_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid |-> !s_axi_arready)
        else protocol_error("ARREADY high while RVALID pending");
    a_no_wr: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid |-> !(|psel && pwrite))
        else protocol_error("new APB write while BVALID pending");
    a_no_rd: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid |-> !(|psel && !pwrite))
        else protocol_error("new APB read while RVALID pending");
    a_quiet: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        quiet_bus |-> psel == '0)
        else protocol_error("PSEL raised for an address outside the windows");
    a_order: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        order_check && |psel && !pwrite |-> wr_setup_seen)
        else protocol_error("read reached the APB bus before the pending write");

    initial begin
        logic [`BRIDGE_ADDR_W-1:0] addr;
        lfsr          = 16'd49;
        data_errs     = 0;
        proto_errs    = 0;
        tmo_errs      = 0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awprot  = 3'd0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'hF;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arprot  = 3'd0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        wait_cfg      = 2'd0;
        quiet_bus     = 1'b0;
        order_check   = 1'b0;
        repeat (10) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);

        // every window, fixed word then a random one
        for (int d = 0; d < `APB_DEV_COUNT; d++) begin
            addr = 20'(d << 12) | 20'h0003C;
            axi_write(addr, rand_bits(32), 0, 0, 0);
            axi_read(addr, 0);
            addr = 20'(d << 12) | (20'(rand_bits(4)) << 2);
            axi_write(addr, rand_bits(32), rand_bits(2), rand_bits(2), rand_bits(3));
            axi_read(addr, rand_bits(3));
        end

        // error register, memory must keep word 15
        for (int d = 0; d < `APB_DEV_COUNT; d++) begin
            addr = 20'(d << 12) | 20'h000FC;
            axi_write(addr, rand_bits(32), 0, 0, rand_bits(2));
            axi_read(addr, 0);
            axi_read(20'(d << 12) | 20'h0003C, 0);
        end

        axi_write(20'h08000, rand_bits(32), 0, 0, 0);
        axi_write(20'hF1004, rand_bits(32), 0, 0, 3);
        axi_read(20'hA3000, 2);

        axi_write(20'h02010, rand_bits(32), 5, 0, 0);  // W well ahead of AW
        axi_write(20'h05020, rand_bits(32), 0, 6, 0);
        order_check = 1'b1;
        fork
            axi_write(20'h06008, rand_bits(32), 0, 0, 2);
            axi_read(20'h02010, 0);
        join
        order_check = 1'b0;
        axi_read(20'h05020, 0);
        axi_read(20'h06008, 1);

        repeat (5) @(negedge S_AXI_ACLK);
        $display("errors: data %0d, protocol %0d, timeout %0d", data_errs, proto_errs, tmo_errs);
        if (data_errs + proto_errs + tmo_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/apb_periph_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "apb_bridge_settings.svh"

module apb_periph_model (
    input  wire                       S_AXI_ACLK,
    input  wire                       S_AXI_ARESETN,
    input  wire [`APB_DEV_COUNT-1:0]  psel,
    input  wire                       penable,
    input  wire [`BRIDGE_ADDR_W-1:0]  paddr,
    input  wire                       pwrite,
    input  wire [`BRIDGE_DATA_W-1:0]  pwdata,
    input  wire [1:0]                 wait_cfg,
    output logic [`BRIDGE_DATA_W-1:0] prdata [`APB_DEV_COUNT],
    output logic [`APB_DEV_COUNT-1:0] pready,
    output logic [`APB_DEV_COUNT-1:0] pslverr
);

    logic [`BRIDGE_DATA_W-1:0] mem [`APB_DEV_COUNT][16];
    logic [1:0]                wait_cnt;
    logic                      err_offset;

    assign err_offset = (paddr[11:0] == 12'h0FC);  // error register

    // device and word both show up in the fill
    initial begin
        for (int d = 0; d < `APB_DEV_COUNT; d++)
            for (int w = 0; w < 16; w++)
                mem[d][w] = 32'h5A00_0000 | (d << 8) | w;
    end

    always_comb begin
        for (int i = 0; i < `APB_DEV_COUNT; i++) begin
            prdata[i]  = mem[i][paddr[5:2]];
            pready[i]  = psel[i] & penable & (wait_cnt == 2'd0);
            pslverr[i] = psel[i] & penable & err_offset;
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN)
            wait_cnt <= 2'd0;
        else if (|psel && !penable)
            wait_cnt <= wait_cfg;  // loaded in SETUP
        else if (penable && wait_cnt != 2'd0)
            wait_cnt <= wait_cnt - 2'd1;
    end

    always @(posedge S_AXI_ACLK) begin
        for (int i = 0; i < `APB_DEV_COUNT; i++)
            if (psel[i] && penable && pwrite && wait_cnt == 2'd0 && !err_offset)
                mem[i][paddr[5:2]] <= pwdata;
    end

endmodule

`default_nettype wire

//--- hdl/apb_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "apb_bridge_settings.svh"

module apb_bridge_top (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire [`BRIDGE_ADDR_W-1:0]        s_axi_awaddr,
    input  wire [2:0]                       s_axi_awprot,
    input  wire                             s_axi_awvalid,
    output wire                             s_axi_awready,
    input  wire [`BRIDGE_DATA_W-1:0]        s_axi_wdata,
    input  wire [`BRIDGE_DATA_W/8-1:0]      s_axi_wstrb,
    input  wire                             s_axi_wvalid,
    output wire                             s_axi_wready,
    output wire apb_bridge_pkg::axi_resp_t  s_axi_bresp,
    output wire                             s_axi_bvalid,
    input  wire                             s_axi_bready,
    input  wire [`BRIDGE_ADDR_W-1:0]        s_axi_araddr,
    input  wire [2:0]                       s_axi_arprot,
    input  wire                             s_axi_arvalid,
    output wire                             s_axi_arready,
    output wire [`BRIDGE_DATA_W-1:0]        s_axi_rdata,
    output wire apb_bridge_pkg::axi_resp_t  s_axi_rresp,
    output wire                             s_axi_rvalid,
    input  wire                             s_axi_rready,
    output wire [`APB_DEV_COUNT-1:0]        psel,
    output wire                             penable,
    output wire [`BRIDGE_ADDR_W-1:0]        paddr,
    output wire                             pwrite,
    output wire [`BRIDGE_DATA_W-1:0]        pwdata,
    input  wire [`BRIDGE_DATA_W-1:0]        prdata [`APB_DEV_COUNT],
    input  wire [`APB_DEV_COUNT-1:0]        pready,
    input  wire [`APB_DEV_COUNT-1:0]        pslverr
);

    import apb_bridge_pkg::*;

    // prot and strobes have no APB counterpart here, taken and dropped

    wire                      start;
    wire                      is_write;
    wire [`BRIDGE_ADDR_W-1:0] req_addr;
    wire [`BRIDGE_DATA_W-1:0] req_wdata;
    wire [`APB_DEV_COUNT-1:0] dev_sel;
    wire                      dec_err;
    wire                      busy;
    wire                      dec_done;
    wire                      xfer_done;
    wire axi_resp_t           xfer_resp;
    wire [`BRIDGE_DATA_W-1:0] xfer_rdata;

    axi_lite_req u_req (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .busy          (busy),
        .xfer_done     (xfer_done),
        .dec_done      (dec_done),
        .xfer_resp     (xfer_resp),
        .xfer_rdata    (xfer_rdata),
        .start         (start),
        .is_write      (is_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata)
    );

    apb_addr_decode u_decode (
        .req_addr (req_addr),
        .dev_sel  (dev_sel),
        .dec_err  (dec_err)
    );

    apb_master_seq u_seq (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (start),
        .is_write      (is_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .dev_sel       (dev_sel),
        .dec_err       (dec_err),
        .xfer_done     (xfer_done),
        .psel          (psel),
        .penable       (penable),
        .paddr         (paddr),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .busy          (busy),
        .dec_done      (dec_done)
    );

    apb_resp_mux u_resp (
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .xfer_done  (xfer_done),
        .xfer_resp  (xfer_resp),
        .xfer_rdata (xfer_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/apb_resp_mux.sv
`timescale 1ns/10ps
`default_nettype none
`include "apb_bridge_settings.svh"

module apb_resp_mux (
    input  wire [`APB_DEV_COUNT-1:0]  psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [`BRIDGE_DATA_W-1:0]  prdata [`APB_DEV_COUNT],
    input  wire [`APB_DEV_COUNT-1:0]  pready,
    input  wire [`APB_DEV_COUNT-1:0]  pslverr,
    output logic                      xfer_done,
    output apb_bridge_pkg::axi_resp_t xfer_resp,
    output logic [`BRIDGE_DATA_W-1:0] xfer_rdata
);

    import apb_bridge_pkg::*;

    logic [`BRIDGE_DATA_W-1:0] rdata_sel;
    logic                      slverr_hit;

    // psel is one-hot, so last match is the only match
    always_comb begin
        rdata_sel = '0;
        for (int i = 0; i < `APB_DEV_COUNT; i++) begin
            if (psel[i])
                rdata_sel = prdata[i];
        end
    end

    // other devices may drive pready/pslverr freely
    assign xfer_done  = penable & |(psel & pready);
    assign slverr_hit = |(psel & pslverr);

    assign xfer_resp  = slverr_hit ? RESP_SLVERR : RESP_OKAY;
    assign xfer_rdata = pwrite ? '0 : rdata_sel;

endmodule

`default_nettype wire

//--- hdl/apb_master_seq.sv
`timescale 1ns/10ps
`default_nettype none
`include "apb_bridge_settings.svh"

module apb_master_seq (
    input  wire                       S_AXI_ACLK,
    input  wire                       S_AXI_ARESETN,
    input  wire                       start,
    input  wire                       is_write,
    input  wire [`BRIDGE_ADDR_W-1:0]  req_addr,
    input  wire [`BRIDGE_DATA_W-1:0]  req_wdata,
    input  wire [`APB_DEV_COUNT-1:0]  dev_sel,
    input  wire                       dec_err,
    input  wire                       xfer_done,
    output logic [`APB_DEV_COUNT-1:0] psel,
    output logic                      penable,
    output logic [`BRIDGE_ADDR_W-1:0] paddr,
    output logic                      pwrite,
    output logic [`BRIDGE_DATA_W-1:0] pwdata,
    output logic                      busy,
    output logic                      dec_done
);

    import apb_bridge_pkg::*;

    apb_phase_t phase;

    assign busy = (phase != PH_IDLE) | dec_done;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            phase    <= PH_IDLE;
            psel     <= '0;
            penable  <= 1'b0;
            dec_done <= 1'b0;
        end else begin
            dec_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        if (dec_err) begin
                            dec_done <= 1'b1;  // bus stays quiet
                        end else begin
                            phase <= PH_SETUP;
                            psel  <= dev_sel;
                        end
                    end
                end
                PH_SETUP: begin
                    phase   <= PH_ACCESS;
                    penable <= 1'b1;
                end
                PH_ACCESS: begin
                    if (xfer_done) begin  // selected pready
                        phase   <= PH_IDLE;
                        penable <= 1'b0;
                        psel    <= '0;
                    end
                end
                default: begin
                    phase   <= PH_IDLE;
                    penable <= 1'b0;
                    psel    <= '0;
                end
            endcase
        end
    end

    // request latched once, held through the whole transfer
    always_ff @(posedge S_AXI_ACLK) begin
        if (phase == PH_IDLE && start) begin
            paddr  <= req_addr;
            pwrite <= is_write;
            pwdata <= req_wdata;
        end
    end

    a_setup_before_access: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(penable) |-> $past(phase) == PH_SETUP && $past(psel) != '0 && $stable(psel));

    a_stable_in_wait: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        penable && !xfer_done |=> $stable(paddr) && $stable(pwrite) && $stable(psel));

endmodule

`default_nettype wire

//--- hdl/apb_addr_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "apb_bridge_settings.svh"

module apb_addr_decode (
    input  wire [`BRIDGE_ADDR_W-1:0] req_addr,
    output logic [`APB_DEV_COUNT-1:0] dev_sel,
    output logic                      dec_err
);

    // first address bit above the device index
    localparam int IDX_HI = `APB_DEV_IDX_LSB + `APB_DEV_IDX_W;

    logic [`APB_DEV_IDX_W-1:0] dev_idx;

    assign dev_idx = req_addr[IDX_HI-1:`APB_DEV_IDX_LSB];
    assign dec_err = |req_addr[`BRIDGE_ADDR_W-1:IDX_HI];  // outside the window block

    always_comb begin
        dev_sel = '0;
        if (!dec_err)
            dev_sel[dev_idx] = 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/axi_lite_req.sv
`timescale 1ns/10ps
`default_nettype none
`include "apb_bridge_settings.svh"

module axi_lite_req (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire [`BRIDGE_ADDR_W-1:0]        s_axi_awaddr,
    input  wire                             s_axi_awvalid,
    output logic                            s_axi_awready,
    input  wire [`BRIDGE_DATA_W-1:0]        s_axi_wdata,
    input  wire                             s_axi_wvalid,
    output logic                            s_axi_wready,
    output apb_bridge_pkg::axi_resp_t       s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  wire                             s_axi_bready,
    input  wire [`BRIDGE_ADDR_W-1:0]        s_axi_araddr,
    input  wire                             s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [`BRIDGE_DATA_W-1:0]       s_axi_rdata,
    output apb_bridge_pkg::axi_resp_t       s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  wire                             s_axi_rready,
    input  wire                             busy,
    input  wire                             xfer_done,
    input  wire                             dec_done,
    input  wire apb_bridge_pkg::axi_resp_t  xfer_resp,
    input  wire [`BRIDGE_DATA_W-1:0]        xfer_rdata,
    output logic                            start,
    output logic                            is_write,
    output logic [`BRIDGE_ADDR_W-1:0]       req_addr,
    output logic [`BRIDGE_DATA_W-1:0]       req_wdata
);

    import apb_bridge_pkg::*;

    logic                      rst_done;
    logic                      aw_full;
    logic                      w_full;
    logic                      ar_full;
    logic                      wr_issued;   // write sent to APB, waiting for B handshake
    logic                      rd_issued;
    logic [`BRIDGE_ADDR_W-1:0] awaddr_q;
    logic [`BRIDGE_DATA_W-1:0] wdata_q;
    logic [`BRIDGE_ADDR_W-1:0] araddr_q;

    logic                      aw_hs;
    logic                      w_hs;
    logic                      ar_hs;
    logic                      b_hs;
    logic                      r_hs;
    logic [`BRIDGE_ADDR_W-1:0] wr_addr;
    logic [`BRIDGE_DATA_W-1:0] wr_data;
    logic [`BRIDGE_ADDR_W-1:0] rd_addr;
    logic                      wr_go;
    logic                      rd_go;
    logic                      issue;
    logic                      done;

    // readies drop on capture, come back after the response handshake
    assign s_axi_awready = rst_done & ~aw_full;
    assign s_axi_wready  = rst_done & ~w_full;
    assign s_axi_arready = rst_done & ~ar_full;

    assign aw_hs = s_axi_awvalid & s_axi_awready;
    assign w_hs  = s_axi_wvalid & s_axi_wready;
    assign ar_hs = s_axi_arvalid & s_axi_arready;
    assign b_hs  = s_axi_bvalid & s_axi_bready;
    assign r_hs  = s_axi_rvalid & s_axi_rready;

    // bypass so a request can start right after its handshake
    assign wr_addr = aw_full ? awaddr_q : s_axi_awaddr;
    assign wr_data = w_full ? wdata_q : s_axi_wdata;
    assign rd_addr = ar_full ? araddr_q : s_axi_araddr;

    assign wr_go = (aw_full | aw_hs) & (w_full | w_hs) & ~wr_issued;
    assign rd_go = (ar_full | ar_hs) & ~rd_issued;
    assign issue = (wr_go | rd_go) & ~start & ~busy;  // write wins below
    assign done  = xfer_done | dec_done;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            rst_done     <= 1'b0;
            aw_full      <= 1'b0;
            w_full       <= 1'b0;
            ar_full      <= 1'b0;
            wr_issued    <= 1'b0;
            rd_issued    <= 1'b0;
            start        <= 1'b0;
            is_write     <= 1'b0;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
        end else begin
            rst_done <= 1'b1;
            start    <= issue;

            if (aw_hs)
                aw_full <= 1'b1;
            if (w_hs)
                w_full <= 1'b1;
            if (ar_hs)
                ar_full <= 1'b1;

            if (issue) begin
                is_write <= wr_go;
                if (wr_go)
                    wr_issued <= 1'b1;
                else
                    rd_issued <= 1'b1;
            end

            if (done && is_write)
                s_axi_bvalid <= 1'b1;
            if (done && !is_write)
                s_axi_rvalid <= 1'b1;

            if (b_hs) begin
                s_axi_bvalid <= 1'b0;
                aw_full      <= 1'b0;
                w_full       <= 1'b0;
                wr_issued    <= 1'b0;
            end
            if (r_hs) begin
                s_axi_rvalid <= 1'b0;
                ar_full      <= 1'b0;
                rd_issued    <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs)
            awaddr_q <= s_axi_awaddr;
        if (w_hs)
            wdata_q <= s_axi_wdata;
        if (ar_hs)
            araddr_q <= s_axi_araddr;

        if (issue) begin
            req_addr <= wr_go ? wr_addr : rd_addr;
            if (wr_go)
                req_wdata <= wr_data;
        end

        if (done && is_write)
            s_axi_bresp <= dec_done ? RESP_DECERR : xfer_resp;
        if (done && !is_write) begin
            s_axi_rresp <= dec_done ? RESP_DECERR : xfer_resp;
            s_axi_rdata <= dec_done ? '0 : xfer_rdata;  // no read data on decode error
        end
    end

    a_no_start_when_busy: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        start |-> !busy);

    a_bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

endmodule

`default_nettype wire

//--- hdl/apb_bridge_pkg.sv
`default_nettype none

package apb_bridge_pkg;

    // BRESP / RRESP encoding, EXOKAY never returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

    // APB transfer phase
    typedef enum logic [1:0] {
        PH_IDLE   = 2'b00,
        PH_SETUP  = 2'b01,  // psel up, penable low
        PH_ACCESS = 2'b10   // penable up until pready
    } apb_phase_t;

endpackage

`default_nettype wire

//--- hdl/apb_bridge_settings.svh
`ifndef APB_BRIDGE_SETTINGS_SVH
`define APB_BRIDGE_SETTINGS_SVH

// data width, shared by AXI and APB
`define BRIDGE_DATA_W 32

// byte address on both sides
`define BRIDGE_ADDR_W 20

// peripheral windows
`define APB_DEV_COUNT 8

// 4 KB per window
`define APB_DEV_IDX_LSB 12
`define APB_DEV_IDX_W 3

`endif
